// File: common/cpu_isa_pkg.sv
// instruction set: word width and opcode values of the accumulator cpu
package cpu_isa_pkg;

	// data and address width
	localparam int WORD_BITS = 8;

	// ------------------------------
	// opcodes
	// ------------------------------
	// every instruction is two words, opcode then operand
	// unlisted opcodes behave as nop
	localparam logic [WORD_BITS - 1 : 0] OP_NOP  = 8'h00;
	// acc = operand
	localparam logic [WORD_BITS - 1 : 0] OP_LDI  = 8'h01;
	// acc = mem[operand]
	localparam logic [WORD_BITS - 1 : 0] OP_LDA  = 8'h02;
	// mem[operand] = acc
	localparam logic [WORD_BITS - 1 : 0] OP_STA  = 8'h03;
	// acc += mem[operand], wraps
	localparam logic [WORD_BITS - 1 : 0] OP_ADD  = 8'h04;
	localparam logic [WORD_BITS - 1 : 0] OP_ADDI = 8'h05;
	localparam logic [WORD_BITS - 1 : 0] OP_ANDI = 8'h06;
	localparam logic [WORD_BITS - 1 : 0] OP_ORI  = 8'h07;
	// pc = operand
	localparam logic [WORD_BITS - 1 : 0] OP_JMP  = 8'h08;
	// restore pc and acc, leave isr
	localparam logic [WORD_BITS - 1 : 0] OP_RETI = 8'h0a;

endpackage

// File: common/sys_pkg.sv
// system level: boot and memory access state encodings, watched address
package sys_pkg;

	// ------------------------------
	// boot sequencer
	// ------------------------------
	typedef enum logic [1 : 0] {
		RESET_ALL,
		COPY_ROM,
		RUN_CPU
	} t_boot_state;

	// ------------------------------
	// cpu memory cycles
	// ------------------------------
	typedef enum logic [1 : 0] {
		MEM_IDLE,
		MEM_READ,
		MEM_PREPARE_WRITE,
		MEM_WRITE
	} t_mem_state;

	// stores here show up on the top level ports
	localparam logic [cpu_isa_pkg::WORD_BITS - 1 : 0] WATCH_ADDR = 8'hff;

endpackage

// File: hw/cpu8/cpu8.sv
// accumulator cpu: fetch/operand/data/execute sequencer, strobe memory port, one irq level
module cpu8 #(
	parameter int ADDR_BITS = 8,
	parameter logic [ADDR_BITS - 1 : 0] ISR_ADDR = 'h20
) (
	input  logic clock,
	input  logic reset,
	input  logic irq,
	input  logic mem_ready,
	input  logic [cpu_isa_pkg::WORD_BITS - 1 : 0] mem_rdata,
	output logic mem_valid,
	output logic [ADDR_BITS - 1 : 0] mem_addr,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] mem_wdata,
	output logic mem_write
);

	localparam int W = cpu_isa_pkg::WORD_BITS;

	// CPU_START is the instruction boundary, no bus access there
	typedef enum logic [2 : 0] {
		CPU_START,
		CPU_FETCH,
		CPU_OPERAND,
		CPU_DATA,
		CPU_EXEC
	} t_cpu_state;

	t_cpu_state state;

	logic [ADDR_BITS - 1 : 0] pc, saved_pc;
	logic [W - 1 : 0] acc, saved_acc;
	logic [W - 1 : 0] ir;
	// operand, replaced by the memory word for lda/add
	logic [W - 1 : 0] opr;
	logic in_isr, irq_pending, irq_q;
	logic needs_data;

	// lda, add and sta touch memory a third time
	assign needs_data = (ir == cpu_isa_pkg::OP_LDA) || (ir == cpu_isa_pkg::OP_ADD)
		|| (ir == cpu_isa_pkg::OP_STA);

	// ------------------------------
	// memory port
	// ------------------------------
	// request held until mem_ready, state only moves on ready
	always_comb begin
		mem_valid = 1'b0;
		mem_write = 1'b0;
		mem_addr = pc;
		case (state)
			CPU_FETCH: begin
				mem_valid = 1'b1;
			end
			CPU_OPERAND: begin
				mem_valid = 1'b1;
				mem_addr = pc + 1'b1;
			end
			CPU_DATA: begin
				mem_valid = 1'b1;
				mem_addr = ADDR_BITS'(opr);
				mem_write = (ir == cpu_isa_pkg::OP_STA);
			end
			default: begin
			end
		endcase
	end

	// only sta puts this on the bus
	assign mem_wdata = acc;

	// ------------------------------
	// sequencer
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CPU_START;
			pc <= '0;
			acc <= '0;
			in_isr <= 1'b0;
			irq_pending <= 1'b0;
			irq_q <= 1'b0;
		end else begin
			irq_q <= irq;
			case (state)
				CPU_START: begin
					// one level only, nested requests wait for reti
					if (irq_pending && !in_isr) begin
						saved_pc <= pc;
						saved_acc <= acc;
						pc <= ISR_ADDR;
						in_isr <= 1'b1;
						irq_pending <= 1'b0;
					end
					state <= CPU_FETCH;
				end
				CPU_FETCH: begin
					if (mem_ready) begin
						ir <= mem_rdata;
						state <= CPU_OPERAND;
					end
				end
				CPU_OPERAND: begin
					if (mem_ready) begin
						opr <= mem_rdata;
						pc <= pc + ADDR_BITS'(2);
						state <= needs_data ? CPU_DATA : CPU_EXEC;
					end
				end
				CPU_DATA: begin
					if (mem_ready) begin
						// loaded word goes into opr so exec sees one source
						if (ir != cpu_isa_pkg::OP_STA)
							opr <= mem_rdata;
						state <= CPU_EXEC;
					end
				end
				CPU_EXEC: begin
					case (ir)
						cpu_isa_pkg::OP_LDI, cpu_isa_pkg::OP_LDA: begin
							acc <= opr;
						end
						cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_ADDI: begin
							acc <= acc + opr;
						end
						cpu_isa_pkg::OP_ANDI: begin
							acc <= acc & opr;
						end
						cpu_isa_pkg::OP_ORI: begin
							acc <= acc | opr;
						end
						cpu_isa_pkg::OP_JMP: begin
							pc <= ADDR_BITS'(opr);
						end
						cpu_isa_pkg::OP_RETI: begin
							pc <= saved_pc;
							acc <= saved_acc;
							in_isr <= 1'b0;
						end
						// nop, sta and unknown opcodes
						default: begin
						end
					endcase
					state <= CPU_START;
				end
				default: begin
					state <= CPU_START;
				end
			endcase
			// new edge wins over the clear in CPU_START
			if (irq && !irq_q)
				irq_pending <= 1'b1;
		end
	end

endmodule

// File: hw/mem/ram_1port.sv
// single-port ram: synchronous write, registered read
module ram_1port #(
	parameter int ADDR_BITS = 8
) (
	input  logic clock,
	input  logic write,
	input  logic [ADDR_BITS - 1 : 0] addr,
	input  logic [cpu_isa_pkg::WORD_BITS - 1 : 0] wdata,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] rdata
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	logic [cpu_isa_pkg::WORD_BITS - 1 : 0] mem [0 : DEPTH - 1];

	// read returns the old word on a write cycle
	always_ff @(posedge clock) begin
		if (write)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// File: hw/mem/rom.sv
// program rom: fibonacci main loop and interrupt counter routine
module rom #(
	parameter int ADDR_BITS = 6
) (
	input  logic [ADDR_BITS - 1 : 0] addr,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] data
);

	localparam int W = cpu_isa_pkg::WORD_BITS;

	// ram variables
	localparam logic [W - 1 : 0] VAR_A   = 8'hf0;
	localparam logic [W - 1 : 0] VAR_B   = 8'hf1;
	localparam logic [W - 1 : 0] VAR_SUM = 8'hf2;
	localparam logic [W - 1 : 0] VAR_IRQ = 8'hfe;

	logic [W - 1 : 0] op, arg;

	// table indexed by instruction, even word opcode, odd word operand
	always_comb begin
		case (addr[ADDR_BITS - 1 : 1])
			// init, irq count first
			'h00: {op, arg} = {cpu_isa_pkg::OP_LDI, 8'h00};
			'h01: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_IRQ};
			'h02: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_A};
			'h03: {op, arg} = {cpu_isa_pkg::OP_LDI, 8'h01};
			'h04: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_B};
			// main loop at 0a
			'h05: {op, arg} = {cpu_isa_pkg::OP_LDA, VAR_A};
			'h06: {op, arg} = {cpu_isa_pkg::OP_ADD, VAR_B};
			'h07: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_SUM};
			'h08: {op, arg} = {cpu_isa_pkg::OP_LDA, VAR_B};
			'h09: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_A};
			'h0a: {op, arg} = {cpu_isa_pkg::OP_LDA, VAR_SUM};
			'h0b: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_B};
			// bit 7 marks isr values on the watch port
			'h0c: {op, arg} = {cpu_isa_pkg::OP_ANDI, 8'h7f};
			'h0d: {op, arg} = {cpu_isa_pkg::OP_STA, sys_pkg::WATCH_ADDR};
			'h0e: {op, arg} = {cpu_isa_pkg::OP_JMP, 8'h0a};
			// isr at 20
			'h10: {op, arg} = {cpu_isa_pkg::OP_LDA, VAR_IRQ};
			'h11: {op, arg} = {cpu_isa_pkg::OP_ADDI, 8'h01};
			'h12: {op, arg} = {cpu_isa_pkg::OP_STA, VAR_IRQ};
			'h13: {op, arg} = {cpu_isa_pkg::OP_ORI, 8'h80};
			'h14: {op, arg} = {cpu_isa_pkg::OP_STA, sys_pkg::WATCH_ADDR};
			'h15: {op, arg} = {cpu_isa_pkg::OP_RETI, 8'h00};
			default: {op, arg} = '0;
		endcase
	end

	assign data = addr[0] ? arg : op;

endmodule

// File: hw/mem/memcpy.sv
// block copier: walks every rom word into ram, one write per cycle
module memcpy #(
	parameter int ADDR_BITS = 6
) (
	input  logic clock,
	input  logic reset,
	input  logic [cpu_isa_pkg::WORD_BITS - 1 : 0] rom_data,
	output logic [ADDR_BITS - 1 : 0] addr,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] data,
	output logic write,
	output logic finished
);

	localparam int NUM_WORDS = 2 ** ADDR_BITS;

	logic [ADDR_BITS - 1 : 0] count;
	logic done;

	// ------------------------------
	// word counter
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			done <= 1'b0;
		end else if (!done) begin
			// last word written this cycle
			if (count == ADDR_BITS'(NUM_WORDS - 1))
				done <= 1'b1;
			count <= count + 1'b1;
		end
	end

	// rom sits on the ram address, so its word already matches addr
	assign addr = count;
	assign data = rom_data;
	assign write = !done;
	// sticky until reset
	assign finished = done;

endmodule

// File: hw/mem_access.sv
// cpu memory cycle controller: read/write wait states, latched store data, watch capture
module mem_access #(
	parameter int ADDR_BITS = 8,
	parameter int READ_CYCLES = 1,
	parameter int WRITE_CYCLES = 2,
	parameter logic [ADDR_BITS - 1 : 0] WATCH_ADDR = sys_pkg::WATCH_ADDR
) (
	input  logic clock,
	input  logic reset,
	input  logic mem_valid,
	input  logic [ADDR_BITS - 1 : 0] mem_addr,
	input  logic [cpu_isa_pkg::WORD_BITS - 1 : 0] mem_wdata,
	input  logic mem_write,
	output logic mem_ready,
	output logic [ADDR_BITS - 1 : 0] ram_addr,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] ram_wdata,
	output logic ram_write,
	output logic writing,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] watch_data,
	output logic watch_strobe
);

	// counters reach READ_CYCLES / WRITE_CYCLES inclusive
	localparam int RCNT_BITS = $clog2(READ_CYCLES + 2);
	localparam int WCNT_BITS = $clog2(WRITE_CYCLES + 2);

	sys_pkg::t_mem_state state, next_state;

	logic [RCNT_BITS - 1 : 0] read_cnt;
	logic [WCNT_BITS - 1 : 0] write_cnt;
	logic [cpu_isa_pkg::WORD_BITS - 1 : 0] wdata_q;
	logic read_done, write_done;

	assign read_done = (read_cnt == RCNT_BITS'(READ_CYCLES));
	assign write_done = (write_cnt == WCNT_BITS'(WRITE_CYCLES));

	// ------------------------------
	// state and counters
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= sys_pkg::MEM_IDLE;
			read_cnt <= '0;
			write_cnt <= '0;
			watch_data <= '0;
			watch_strobe <= 1'b0;
		end else begin
			state <= next_state;
			watch_strobe <= 1'b0;

			if (state == sys_pkg::MEM_READ && !read_done)
				read_cnt <= read_cnt + 1'b1;
			else
				read_cnt <= '0;

			if (state == sys_pkg::MEM_WRITE && !write_done)
				write_cnt <= write_cnt + 1'b1;
			else
				write_cnt <= '0;

			// strobe lands in the first write cycle
			if (state == sys_pkg::MEM_PREPARE_WRITE && mem_addr == WATCH_ADDR) begin
				watch_data <= mem_wdata;
				watch_strobe <= 1'b1;
			end
		end
	end

	// store data held steady over the whole write phase
	always_ff @(posedge clock) begin
		if (state == sys_pkg::MEM_PREPARE_WRITE)
			wdata_q <= mem_wdata;
	end

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		next_state = state;
		case (state)
			sys_pkg::MEM_IDLE: begin
				if (mem_valid)
					next_state = mem_write ? sys_pkg::MEM_PREPARE_WRITE : sys_pkg::MEM_READ;
			end
			sys_pkg::MEM_READ: begin
				if (read_done)
					next_state = sys_pkg::MEM_IDLE;
			end
			sys_pkg::MEM_PREPARE_WRITE: begin
				next_state = sys_pkg::MEM_WRITE;
			end
			sys_pkg::MEM_WRITE: begin
				// read phase after a store provides the ready pulse
				if (write_done)
					next_state = sys_pkg::MEM_READ;
			end
			default: begin
				next_state = sys_pkg::MEM_IDLE;
			end
		endcase
	end

	// cpu holds its address for the whole access
	assign ram_addr = mem_addr;
	assign ram_wdata = wdata_q;
	assign ram_write = (state == sys_pkg::MEM_WRITE);
	assign writing = ram_write;
	assign mem_ready = (state == sys_pkg::MEM_READ) && read_done;

endmodule

// File: hw/cpuctrl.sv
// system top: boot sequencer, ram port mux, status decode, rom/ram/memcpy/mem_access/cpu instances
module cpuctrl #(
	parameter int ADDR_BITS = 8,
	parameter int ROM_ADDR_BITS = 6,
	parameter logic [ADDR_BITS - 1 : 0] ISR_ADDR = 'h20,
	parameter int READ_CYCLES = 1,
	parameter int WRITE_CYCLES = 2,
	parameter logic [ADDR_BITS - 1 : 0] WATCH_ADDR = sys_pkg::WATCH_ADDR
) (
	input  logic clock,
	input  logic reset,
	input  logic irq,
	output logic booting,
	output logic running,
	output logic writing,
	output logic [cpu_isa_pkg::WORD_BITS - 1 : 0] watch_data,
	output logic watch_strobe
);

	localparam int W = cpu_isa_pkg::WORD_BITS;

	sys_pkg::t_boot_state state, next_state;
	logic sys_reset, cpu_hold, copy_last;

	// ram port and its two masters
	logic [ADDR_BITS - 1 : 0] ram_addr, acc_addr, cpu_addr;
	logic [W - 1 : 0] ram_wdata, ram_rdata, acc_wdata, cpu_wdata;
	logic ram_write, acc_write;
	logic [ROM_ADDR_BITS - 1 : 0] copy_addr;
	logic [W - 1 : 0] copy_data, rom_data;
	logic copy_write;
	logic cpu_valid, cpu_ready, cpu_write;

	// ------------------------------
	// boot sequencer
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset)
			state <= sys_pkg::RESET_ALL;
		else
			state <= next_state;
	end

	// leave COPY_ROM on the edge where memcpy raises finished
	assign copy_last = copy_write && (copy_addr == '1);

	always_comb begin
		next_state = state;
		case (state)
			sys_pkg::RESET_ALL: begin
				next_state = sys_pkg::COPY_ROM;
			end
			sys_pkg::COPY_ROM: begin
				if (copy_last)
					next_state = sys_pkg::RUN_CPU;
			end
			sys_pkg::RUN_CPU: begin
			end
			default: begin
				next_state = sys_pkg::RESET_ALL;
			end
		endcase
	end

	// reset term covers the first cycle before state settles
	assign sys_reset = reset || (state == sys_pkg::RESET_ALL);
	// cpu only runs once the copy is done
	assign cpu_hold = reset || (state != sys_pkg::RUN_CPU);

	assign booting = (state == sys_pkg::COPY_ROM);
	assign running = (state == sys_pkg::RUN_CPU);

	// ------------------------------
	// ram port mux
	// ------------------------------
	always_comb begin
		if (state == sys_pkg::RUN_CPU) begin
			ram_addr = acc_addr;
			ram_wdata = acc_wdata;
			ram_write = acc_write;
		end else begin
			ram_addr = ADDR_BITS'(copy_addr);
			ram_wdata = copy_data;
			ram_write = copy_write;
		end
	end

	// ------------------------------
	// instances
	// ------------------------------
	rom #(.ADDR_BITS(ROM_ADDR_BITS)) i_rom (
		.addr(ram_addr[ROM_ADDR_BITS - 1 : 0]),
		.data(rom_data)
	);

	memcpy #(.ADDR_BITS(ROM_ADDR_BITS)) i_memcpy (
		.clock(clock),
		.reset(sys_reset),
		.rom_data(rom_data),
		.addr(copy_addr),
		.data(copy_data),
		.write(copy_write),
		.finished()
	);

	ram_1port #(.ADDR_BITS(ADDR_BITS)) i_ram (
		.clock(clock),
		.write(ram_write),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	mem_access #(
		.ADDR_BITS(ADDR_BITS),
		.READ_CYCLES(READ_CYCLES),
		.WRITE_CYCLES(WRITE_CYCLES),
		.WATCH_ADDR(WATCH_ADDR)
	) i_mem_access (
		.clock(clock),
		.reset(sys_reset),
		.mem_valid(cpu_valid),
		.mem_addr(cpu_addr),
		.mem_wdata(cpu_wdata),
		.mem_write(cpu_write),
		.mem_ready(cpu_ready),
		.ram_addr(acc_addr),
		.ram_wdata(acc_wdata),
		.ram_write(acc_write),
		.writing(writing),
		.watch_data(watch_data),
		.watch_strobe(watch_strobe)
	);

	cpu8 #(.ADDR_BITS(ADDR_BITS), .ISR_ADDR(ISR_ADDR)) i_cpu (
		.clock(clock),
		.reset(cpu_hold),
		.irq(irq),
		.mem_ready(cpu_ready),
		.mem_rdata(ram_rdata),
		.mem_valid(cpu_valid),
		.mem_addr(cpu_addr),
		.mem_wdata(cpu_wdata),
		.mem_write(cpu_write)
	);

endmodule

// File: verif/tb_clock.sv
// testbench clock generator and reset source with restart request
module tb_clock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 2
) (
	input  logic restart,
	output logic clock,
	output logic reset
);

	// reset cycles still to go
	int hold = RESET_CYCLES;

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// restart re-arms the full reset length
	always @(posedge clock) begin
		if (restart)
			hold <= RESET_CYCLES;
		else if (hold != 0)
			hold <= hold - 1;
	end

	assign reset = (hold != 0);

endmodule

// File: verif/tb_checker.sv
// testbench checker: fibonacci and interrupt reference functions, boot, value and write timing checks
module tb_checker #(
	parameter int BOOT_CYCLES = 64,
	parameter int WRITE_PULSE = 3
) (
	input  logic clock,
	input  logic reset,
	input  logic irq,
	input  logic booting,
	input  logic running,
	input  logic writing,
	input  logic [cpu_isa_pkg::WORD_BITS - 1 : 0] watch_data,
	input  logic watch_strobe,
	output logic boot_done,
	output int fib_seen,
	output int isr_seen,
	output int write_pulses,
	output int checks,
	output int errors,
	output int timing_errors
);

	localparam int W = cpu_isa_pkg::WORD_BITS;

	// booting cycles since reset
	int boot_cycles;
	// length of the writing pulse in progress
	int write_run;
	// irq rising edges since reset
	int irq_count;
	logic irq_prev;

	// ------------------------------
	// reference models
	// ------------------------------
	// value of store number index after reset, sum wraps at 256
	function automatic logic [W - 1 : 0] fib_expected(input int index);
		logic [W - 1 : 0] a, b, sum;
		int i;
		a = 8'h00;
		b = 8'h01;
		sum = 8'h00;
		for (i = 0; i <= index; i++) begin
			sum = a + b;
			a = b;
			b = sum;
		end
		// bit 7 stays free for isr values
		return sum & 8'h7f;
	endfunction

	// isr store: pulse count with the marker bit
	function automatic logic [W - 1 : 0] isr_expected(input int pulses);
		logic [W - 1 : 0] count;
		count = pulses[W - 1 : 0];
		return 8'h80 | count;
	endfunction

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic compare_value(input string name, input logic [W - 1 : 0] expected,
		input logic [W - 1 : 0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic complain(input string text);
		errors++;
		$display("%s", text);
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	// copy phase length, no cpu traffic while copying
	task automatic track_boot();
		if (booting) begin
			boot_cycles++;
			if (watch_strobe || writing)
				complain("cpu memory traffic seen while booting");
		end
		if (running) begin
			checks++;
			if (boot_cycles != BOOT_CYCLES)
				complain($sformatf("booting lasted %0d cycles instead of %0d",
					boot_cycles, BOOT_CYCLES));
			boot_done = 1'b1;
		end
	endtask

	// length judged on the falling edge of writing
	task automatic measure_write_pulse();
		if (writing) begin
			write_run++;
		end else if (write_run != 0) begin
			checks++;
			write_pulses++;
			if (write_run != WRITE_PULSE) begin
				timing_errors++;
				complain($sformatf("writing pulse lasted %0d cycles instead of %0d",
					write_run, WRITE_PULSE));
			end
			write_run = 0;
		end
	endtask

	// bit 7 picks the isr reference, else next fibonacci value
	task automatic judge_strobe();
		if (!writing) begin
			timing_errors++;
			complain("watch_strobe came outside a writing pulse");
		end
		if (watch_data[W - 1]) begin
			compare_value("watch_data", isr_expected(irq_count), watch_data);
			isr_seen++;
		end else begin
			compare_value("watch_data", fib_expected(fib_seen), watch_data);
			fib_seen++;
		end
	endtask

	initial begin
		checks = 0;
		errors = 0;
		timing_errors = 0;
		write_pulses = 0;
	end

	// sampled mid-cycle, away from the stimulus edge
	always @(negedge clock) begin
		if (reset !== 1'b0) begin
			// references restart with the system
			boot_done = 1'b0;
			boot_cycles = 0;
			fib_seen = 0;
			isr_seen = 0;
			irq_count = 0;
			write_run = 0;
			irq_prev = 1'b0;
		end else begin
			if (irq && !irq_prev)
				irq_count++;
			irq_prev = irq;
			measure_write_pulse();
			if (!boot_done) begin
				track_boot();
			end else if (!running) begin
				complain("running dropped without a reset");
				boot_done = 1'b0;
			end
			if (boot_done && watch_strobe)
				judge_strobe();
		end
	end

endmodule

// File: verif/tb_cpuctrl.sv
// testbench top: clock source, DUT, checker, lfsr, irq stimulus, test sequence and timeout
module tb_cpuctrl;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 2;
	localparam int BOOT_CYCLES = 64;
	localparam int WRITE_PULSE = 3;
	// run budget, about 40 stores of 90 cycles per test
	localparam int NUM_TESTS = 5;
	localparam int STORES_PER_TEST = 40;
	localparam int CYCLES_PER_STORE = 90;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * STORES_PER_TEST * CYCLES_PER_STORE * 5 / 3;
	localparam int FIB_VALUES = 30;
	localparam int IRQ_PULSES = 12;
	localparam int IRQ_WIDTH = 2;
	localparam int IRQ_GAP_MIN = 10;
	localparam int WRITE_PULSES = 20;

	logic clock, reset;
	logic restart = 1'b0;
	logic irq = 1'b0;
	logic booting, running, writing, watch_strobe;
	logic [cpu_isa_pkg::WORD_BITS - 1 : 0] watch_data;

	// checker status
	logic boot_done;
	int fib_seen, isr_seen, write_pulses, checks, errors, timing_errors;

	logic [31 : 0] lfsr = 32'hb33d;
	int cycles = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// ------------------------------
	// instances
	// ------------------------------
	tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock (
		.restart(restart),
		.clock(clock),
		.reset(reset)
	);

	cpuctrl i_dut (
		.clock(clock),
		.reset(reset),
		.irq(irq),
		.booting(booting),
		.running(running),
		.writing(writing),
		.watch_data(watch_data),
		.watch_strobe(watch_strobe)
	);

	tb_checker #(.BOOT_CYCLES(BOOT_CYCLES), .WRITE_PULSE(WRITE_PULSE)) i_checker (
		.clock(clock),
		.reset(reset),
		.irq(irq),
		.booting(booting),
		.running(running),
		.writing(writing),
		.watch_data(watch_data),
		.watch_strobe(watch_strobe),
		.boot_done(boot_done),
		.fib_seen(fib_seen),
		.isr_seen(isr_seen),
		.write_pulses(write_pulses),
		.checks(checks),
		.errors(errors),
		.timing_errors(timing_errors)
	);

	// ------------------------------
	// helpers
	// ------------------------------
	// galois form, taps 32 22 2 1
	function automatic logic [31 : 0] lfsr_next(input logic [31 : 0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int count, output int value);
		int i;
		value = 0;
		for (i = 0; i < count; i++) begin
			value = 2 * value + (lfsr[0] ? 1 : 0);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	task automatic send_irq();
		irq <= 1'b1;
		wait_cycles(IRQ_WIDTH);
		irq <= 1'b0;
	endtask

	task automatic close_test(input string name, input int failures);
		tests_run++;
		if (failures == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, failures);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		int start_errors;
		int gap;
		int target;
		int k;
		@(posedge clock);

		// boot after power-on reset
		start_errors = errors;
		while (boot_done !== 1'b1) @(posedge clock);
		close_test("boot", errors - start_errors);

		// fibonacci stores with irq idle
		start_errors = errors;
		while (fib_seen < FIB_VALUES) @(posedge clock);
		close_test("program result", errors - start_errors);

		// next pulse only once the previous isr value was seen
		start_errors = errors;
		for (k = 1; k <= IRQ_PULSES; k++) begin
			draw_bits(6, gap);
			wait_cycles(IRQ_GAP_MIN + gap);
			send_irq();
			while (isr_seen < k) @(posedge clock);
		end
		// main loop resumes after the last return
		target = fib_seen + 3;
		while (fib_seen < target) @(posedge clock);
		close_test("interrupts", errors - start_errors);

		// pulse lengths checked over the whole run
		target = write_pulses + WRITE_PULSES;
		while (write_pulses < target) @(posedge clock);
		close_test("write timing", timing_errors);

		// reset while running, references start over
		start_errors = errors;
		restart <= 1'b1;
		@(posedge clock);
		restart <= 1'b0;
		while (boot_done === 1'b1) @(posedge clock);
		while (boot_done !== 1'b1) @(posedge clock);
		// program init clears the irq count before the first store
		while (fib_seen < 2) @(posedge clock);
		send_irq();
		while (isr_seen < 1) @(posedge clock);
		target = fib_seen + 2;
		while (fib_seen < target) @(posedge clock);
		close_test("reset mid-run", errors - start_errors);

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// ------------------------------
	// timeout
	// ------------------------------
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

endmodule

// File: vlog.f
common/cpu_isa_pkg.sv
common/sys_pkg.sv
hw/cpu8/cpu8.sv
hw/mem/ram_1port.sv
hw/mem/rom.sv
hw/mem/memcpy.sv
hw/mem_access.sv
hw/cpuctrl.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_cpuctrl.sv

// File: Makefile
TOP = tb_cpuctrl
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
